//--- common/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath word width
`define MIPS_DATA_WIDTH 32

// general register file geometry
`define MIPS_REG_COUNT 32
`define MIPS_REG_ADDR_WIDTH 5

// value held by every register after reset
`define MIPS_REG_RESET 0

`endif

//--- common/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegimm  = 6'b000001;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opBlez    = 6'b000110;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opSltiu   = 6'b001011;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;

    localparam logic [5:0] fnJr      = 6'b001000;
    localparam logic [5:0] fnJalr    = 6'b001001;
    localparam logic [5:0] fnAddu    = 6'b100001;
    localparam logic [5:0] fnSlt     = 6'b101010;
    localparam logic [5:0] fnSltu    = 6'b101011;

    // rt field selects the REGIMM branch flavour
    localparam logic [4:0] rtBltz    = 5'b00000;
    localparam logic [4:0] rtBgez    = 5'b00001;
    localparam logic [4:0] rtBltzal  = 5'b10000;
    localparam logic [4:0] rtBgezal  = 5'b10001;

    // early data result sources
    localparam logic [1:0] dselLink  = 2'b00;
    localparam logic [1:0] dselLui   = 2'b01;
    localparam logic [1:0] dselSet   = 2'b10;

    typedef enum logic [2:0] {
        cmpNe   = 3'd0,
        cmpLtz  = 3'd1,
        cmpLez  = 3'd2,
        cmpEq   = 3'd3,
        cmpGez  = 3'd4,
        cmpGtz  = 3'd5,
        cmpTrue = 3'd6,  // unconditional transfers
        cmpLt   = 3'd7   // set-on-less-than
    } cmpMode;

    typedef struct packed {
        logic [5:0]                      opcode;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                      shamt;
        logic [5:0]                      funct;
    } rFormat;

    typedef struct packed {
        logic [5:0]                      opcode;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                     imm16;
    } iFormat;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } jFormat;

    typedef union packed {
        rFormat rView;
        iFormat iView;
        jFormat jView;
    } instrUnion;

endpackage

//--- id/idComparer.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module idComparer (
    input  logic [`MIPS_DATA_WIDTH-1:0] a,
    input  logic [`MIPS_DATA_WIDTH-1:0] b,
    input  mips_pkg::cmpMode            cmpSel,
    input  logic                        signedCmp,
    output logic                        cmpResult
);
    import mips_pkg::*;

    logic eq;
    logic lt;

    assign eq = (a == b);

    // zero compares see b as register 0, so one less-than covers all
    assign lt = signedCmp ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (cmpSel)
            cmpNe:   cmpResult = ~eq;
            cmpLtz:  cmpResult = lt;
            cmpLez:  cmpResult = lt | eq;
            cmpEq:   cmpResult = eq;
            cmpGez:  cmpResult = ~lt;
            cmpGtz:  cmpResult = ~(lt | eq);
            cmpLt:   cmpResult = lt;
            default: cmpResult = 1'b1;  // cmpTrue
        endcase
    end

endmodule

//--- id/idController.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module idController (
    input  mips_pkg::instrUnion              inst,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0]  readAddrB,
    output logic                             bSelImm,
    output logic [1:0]                       dataSel,
    output logic                             signedCmp,
    output mips_pkg::cmpMode                 cmpSel,
    output logic                             signedExt,
    output logic                             jumpReg,
    output logic                             jumpImm,
    output logic                             isBranch
);
    import mips_pkg::*;

    logic [5:0] op;
    logic [4:0] rt;
    logic [5:0] fn;
    logic       isBltzAny;  // bltz / bltzal
    logic       isBgezAny;  // bgez / bgezal
    logic       isJr;
    logic       isJalr;
    logic       isSlt;
    logic       isSltu;

    assign op = inst.rView.opcode;
    assign rt = inst.rView.rt;
    assign fn = inst.rView.funct;

    assign isBltzAny = (op == opRegimm) && (rt == rtBltz || rt == rtBltzal);
    assign isBgezAny = (op == opRegimm) && (rt == rtBgez || rt == rtBgezal);
    assign isJr      = (op == opSpecial) && (fn == fnJr);
    assign isJalr    = (op == opSpecial) && (fn == fnJalr);
    assign isSlt     = (op == opSpecial) && (fn == fnSlt);
    assign isSltu    = (op == opSpecial) && (fn == fnSltu);

    // zero-compare branches read register 0 as operand b
    assign readAddrB = (isBltzAny || isBgezAny || op == opBlez || op == opBgtz) ?
                       '0 : inst.iView.rt;

    assign bSelImm   = (op == opSlti) || (op == opSltiu);
    assign signedCmp = ~(isSltu || op == opSltiu);  // only the unsigned forms clear it

    always_comb begin
        if (op == opLui) begin
            dataSel = dselLui;
        end else if (isSlt || isSltu || op == opSlti || op == opSltiu) begin
            dataSel = dselSet;
        end else begin
            dataSel = dselLink;  // jal, jalr, bltzal and bgezal land here
        end
    end

    // comparer output doubles as the taken condition, so anything
    // without a relation of its own resolves as true
    always_comb begin
        cmpSel = cmpTrue;
        if (op == opBne) begin
            cmpSel = cmpNe;
        end else if (isBltzAny) begin
            cmpSel = cmpLtz;
        end else if (op == opBlez) begin
            cmpSel = cmpLez;
        end else if (op == opBeq) begin
            cmpSel = cmpEq;
        end else if (isBgezAny) begin
            cmpSel = cmpGez;
        end else if (op == opBgtz) begin
            cmpSel = cmpGtz;
        end else if (isSlt || isSltu || op == opSlti || op == opSltiu) begin
            cmpSel = cmpLt;
        end
    end

    assign signedExt = (op == opAddi)  || (op == opAddiu) ||  // arithmetic
                       (op == opBeq)   || (op == opBne)   ||
                       (op == opBlez)  || (op == opBgtz)  ||
                       (op == opRegimm) ||                    // all regimm branches
                       (op == opSlti)  || (op == opSltiu) ||
                       (op == opLw)    || (op == opSw);       // address offsets

    assign jumpReg  = isJr || isJalr;
    assign jumpImm  = (op == opJ) || (op == opJal);

    assign isBranch = (op == opBeq) || (op == opBne)  ||
                      (op == opBlez) || (op == opBgtz) ||
                      (op == opRegimm) ||
                      jumpImm || jumpReg;

endmodule

//--- id/idNextPc.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module idNextPc (
    input  mips_pkg::instrUnion          inst,
    input  logic [`MIPS_DATA_WIDTH-1:0]  pc,
    input  logic [`MIPS_DATA_WIDTH-1:0]  extImm,
    input  logic [`MIPS_DATA_WIDTH-1:0]  rsValue,
    input  logic                         jumpReg,
    input  logic                         jumpImm,
    input  logic                         isBranch,
    input  logic                         cmpResult,
    output logic [`MIPS_DATA_WIDTH-1:0]  branchTarget,
    output logic                         branchTaken
);
    logic [`MIPS_DATA_WIDTH-1:0] pcPlus4;
    logic [`MIPS_DATA_WIDTH-1:0] jumpTarget;
    logic [`MIPS_DATA_WIDTH-1:0] relTarget;

    assign pcPlus4    = pc + `MIPS_DATA_WIDTH'd4;
    assign jumpTarget = {pcPlus4[`MIPS_DATA_WIDTH-1 -: 4], inst.jView.index26, 2'b00};
    assign relTarget  = pcPlus4 + (extImm << 2);  // word offset from the delay slot

    always_comb begin
        if (jumpReg) begin
            branchTarget = rsValue;  // jr / jalr
        end else if (jumpImm) begin
            branchTarget = jumpTarget;
        end else begin
            branchTarget = relTarget;
        end
    end

    // comparer already reports true for unconditional transfers
    assign branchTaken = isBranch & cmpResult;

endmodule

//--- id/idOperand.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module idOperand (
    input  mips_pkg::instrUnion          inst,
    input  logic [`MIPS_DATA_WIDTH-1:0]  pc,
    input  logic [`MIPS_DATA_WIDTH-1:0]  rtValue,
    input  logic                         signedExt,
    input  logic                         bSelImm,
    input  logic [1:0]                   dataSel,
    input  logic                         cmpResult,
    output logic [`MIPS_DATA_WIDTH-1:0]  cmpB,
    output logic [`MIPS_DATA_WIDTH-1:0]  extImm,
    output logic [`MIPS_DATA_WIDTH-1:0]  idData
);
    import mips_pkg::*;

    logic [15:0] imm;

    assign imm = inst.iView.imm16;

    assign extImm = signedExt ? {{(`MIPS_DATA_WIDTH-16){imm[15]}}, imm} :
                                {{(`MIPS_DATA_WIDTH-16){1'b0}}, imm};

    // slti / sltiu compare rs against the immediate
    assign cmpB = bSelImm ? extImm : rtValue;

    always_comb begin
        case (dataSel)
            dselLui: idData = {imm, {(`MIPS_DATA_WIDTH-16){1'b0}}};
            dselSet: idData = {{(`MIPS_DATA_WIDTH-1){1'b0}}, cmpResult};
            default: idData = pc + `MIPS_DATA_WIDTH'd8;  // link skips the delay slot
        endcase
    end

endmodule

//--- id/idStage.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module idStage (
    input  logic                            clk,
    input  logic                            rst,
    input  mips_pkg::instrUnion             inst,
    input  logic [`MIPS_DATA_WIDTH-1:0]     pc,
    input  logic                            wbWriteEnable,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] wbWriteAddr,
    input  logic [`MIPS_DATA_WIDTH-1:0]     wbWriteData,
    output logic [`MIPS_DATA_WIDTH-1:0]     rsValue,
    output logic [`MIPS_DATA_WIDTH-1:0]     rtValue,
    output logic [`MIPS_DATA_WIDTH-1:0]     extImm,
    output logic [`MIPS_DATA_WIDTH-1:0]     idData,
    output logic [`MIPS_DATA_WIDTH-1:0]     branchTarget,
    output logic                            branchTaken,
    output logic                            isBranch
);
    import mips_pkg::*;

    logic [`MIPS_REG_ADDR_WIDTH-1:0] readAddrB;
    logic                            bSelImm;
    logic [1:0]                      dataSel;
    logic                            signedCmp;
    cmpMode                          cmpSel;
    logic                            signedExt;
    logic                            jumpReg;
    logic                            jumpImm;
    logic [`MIPS_DATA_WIDTH-1:0]     cmpB;
    logic                            cmpResult;

    idController ctrl (
        .inst(inst), .readAddrB(readAddrB), .bSelImm(bSelImm), .dataSel(dataSel),
        .signedCmp(signedCmp), .cmpSel(cmpSel), .signedExt(signedExt),
        .jumpReg(jumpReg), .jumpImm(jumpImm), .isBranch(isBranch)
    );

    regFile grf (
        .clk(clk), .rst(rst),
        .readAddrA(inst.rView.rs), .readAddrB(readAddrB),  // port a always reads rs
        .readDataA(rsValue), .readDataB(rtValue),
        .writeEnable(wbWriteEnable), .writeAddr(wbWriteAddr), .writeData(wbWriteData)
    );

    idOperand operand (
        .inst(inst), .pc(pc), .rtValue(rtValue), .signedExt(signedExt),
        .bSelImm(bSelImm), .dataSel(dataSel), .cmpResult(cmpResult),
        .cmpB(cmpB), .extImm(extImm), .idData(idData)
    );

    idComparer comparer (
        .a(rsValue), .b(cmpB), .cmpSel(cmpSel), .signedCmp(signedCmp),
        .cmpResult(cmpResult)
    );

    idNextPc nextPc (
        .inst(inst), .pc(pc), .extImm(extImm), .rsValue(rsValue),
        .jumpReg(jumpReg), .jumpImm(jumpImm), .isBranch(isBranch),
        .cmpResult(cmpResult), .branchTarget(branchTarget), .branchTaken(branchTaken)
    );

endmodule

//--- rtl/regFile.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module regFile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] readAddrA,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] readAddrB,
    output logic [`MIPS_DATA_WIDTH-1:0]     readDataA,
    output logic [`MIPS_DATA_WIDTH-1:0]     readDataB,
    input  logic                            writeEnable,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [`MIPS_DATA_WIDTH-1:0]     writeData
);
    logic [`MIPS_DATA_WIDTH-1:0] regs [`MIPS_REG_COUNT];
    logic                        writeLive;

    assign writeLive = writeEnable && (writeAddr != '0);  // r0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= `MIPS_DATA_WIDTH'(`MIPS_REG_RESET);
            end
        end else if (writeLive) begin
            regs[writeAddr] <= writeData;
        end
    end

    // same-cycle write-back is forwarded to the readers
    always_comb begin
        if (readAddrA == '0) begin
            readDataA = '0;
        end else if (writeLive && writeAddr == readAddrA) begin
            readDataA = writeData;
        end else begin
            readDataA = regs[readAddrA];
        end
        if (readAddrB == '0) begin
            readDataB = '0;
        end else if (writeLive && writeAddr == readAddrB) begin
            readDataB = writeData;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f vlog.f --top-module idStage_tb -o simv &&
    ./obj_dir/simv +verilator+error+limit+100000 > sim.log 2>&1 ||
    { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

//--- sim/idStage_checker.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module idStage_checker (
    input logic                            clk,
    input logic                            rst,
    input mips_pkg::instrUnion             inst,
    input logic [`MIPS_DATA_WIDTH-1:0]     pc,
    input logic                            wbWriteEnable,
    input logic [`MIPS_REG_ADDR_WIDTH-1:0] wbWriteAddr,
    input logic [`MIPS_DATA_WIDTH-1:0]     wbWriteData,
    input logic [`MIPS_DATA_WIDTH-1:0]     rsValue,
    input logic [`MIPS_DATA_WIDTH-1:0]     rtValue,
    input logic [`MIPS_DATA_WIDTH-1:0]     extImm,
    input logic [`MIPS_DATA_WIDTH-1:0]     idData,
    input logic [`MIPS_DATA_WIDTH-1:0]     branchTarget,
    input logic                            branchTaken,
    input logic                            isBranch
);
    import mips_pkg::*;

    logic [`MIPS_DATA_WIDTH-1:0]     shadow [`MIPS_REG_COUNT];
    logic [5:0]                      op;
    logic [5:0]                      fn;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rtAddr;
    logic [`MIPS_DATA_WIDTH-1:0]     expRs;
    logic [`MIPS_DATA_WIDTH-1:0]     expRt;
    logic [`MIPS_DATA_WIDTH-1:0]     sImm;
    logic [`MIPS_DATA_WIDTH-1:0]     pcPlus4;
    logic [`MIPS_DATA_WIDTH-1:0]     expExt;
    logic [`MIPS_DATA_WIDTH-1:0]     expTarget;
    logic [`MIPS_DATA_WIDTH-1:0]     expData;
    logic                            isXfer;
    logic                            expTaken;
    logic                            hasData;
    int                              failCount = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            shadow <= '{default: `MIPS_DATA_WIDTH'(`MIPS_REG_RESET)};
        end else if (wbWriteEnable && wbWriteAddr != '0) begin
            shadow[wbWriteAddr] <= wbWriteData;
        end
    end

    assign op      = inst.rView.opcode;
    assign fn      = inst.rView.funct;
    assign rs      = inst.rView.rs;
    assign rtAddr  = (op inside {opRegimm, opBlez, opBgtz}) ? '0 : inst.rView.rt;  // compare to r0
    assign expRs   = (rs == '0) ? '0 :
                     (wbWriteEnable && wbWriteAddr == rs) ? wbWriteData : shadow[rs];
    assign expRt   = (rtAddr == '0) ? '0 :
                     (wbWriteEnable && wbWriteAddr == rtAddr) ? wbWriteData : shadow[rtAddr];
    assign sImm    = {{16{inst.iView.imm16[15]}}, inst.iView.imm16};
    assign pcPlus4 = pc + `MIPS_DATA_WIDTH'd4;

    always_comb begin
        isXfer    = 1'b1;
        expTaken  = 1'b1;
        expTarget = pcPlus4 + (sImm << 2);
        hasData   = 1'b0;
        expData   = pc + `MIPS_DATA_WIDTH'd8;  // link address
        case (op)
            opBeq:  expTaken = (expRs == expRt);
            opBne:  expTaken = (expRs != expRt);
            opBlez: expTaken = ($signed(expRs) <= 0);
            opBgtz: expTaken = ($signed(expRs) > 0);
            opRegimm: begin
                expTaken = inst.rView.rt[0] ? ($signed(expRs) >= 0) : ($signed(expRs) < 0);
                hasData  = inst.rView.rt[4];  // bltzal / bgezal
            end
            opJ, opJal: begin
                expTarget = {pcPlus4[`MIPS_DATA_WIDTH-1 -: 4], inst.jView.index26, 2'b00};
                hasData   = (op == opJal);
            end
            opSpecial: begin
                isXfer    = (fn == fnJr) || (fn == fnJalr);
                expTarget = expRs;
                hasData   = (fn == fnJalr) || (fn == fnSlt) || (fn == fnSltu);
                if (fn == fnSlt) begin
                    expData = `MIPS_DATA_WIDTH'($signed(expRs) < $signed(expRt));
                end else if (fn == fnSltu) begin
                    expData = `MIPS_DATA_WIDTH'(expRs < expRt);
                end
            end
            opSlti, opSltiu: begin
                isXfer  = 1'b0;
                hasData = 1'b1;
                expData = (op == opSlti) ? `MIPS_DATA_WIDTH'($signed(expRs) < $signed(sImm)) :
                                           `MIPS_DATA_WIDTH'(expRs < sImm);
            end
            opLui: begin
                isXfer  = 1'b0;
                hasData = 1'b1;
                expData = {inst.iView.imm16, 16'h0};
            end
            default: isXfer = 1'b0;
        endcase
        expExt = {16'h0, inst.iView.imm16};
        if (op inside {opAddi, opAddiu, opSlti, opSltiu, opLw, opSw,
                       opBeq, opBne, opBlez, opBgtz, opRegimm}) begin
            expExt = sImm;
        end
    end

    regRead: assert property (@(negedge clk) disable iff (rst)
        rsValue == expRs && rtValue == expRt)
        else begin
            failCount++;
            $error("CHECK FAILED regRead: expected %h %h actual %h %h",
                   expRs, expRt, rsValue, rtValue);
        end

    transfer: assert property (@(negedge clk) disable iff (rst)
        isXfer |-> (branchTaken == expTaken && branchTarget == expTarget))
        else begin
            failCount++;
            $error("CHECK FAILED transfer: expected %b %h actual %b %h",
                   expTaken, expTarget, branchTaken, branchTarget);
        end

    earlyData: assert property (@(negedge clk) disable iff (rst)
        hasData |-> idData == expData)
        else begin
            failCount++;
            $error("CHECK FAILED earlyData: expected %h actual %h", expData, idData);
        end

    extend: assert property (@(negedge clk) disable iff (rst) extImm == expExt)
        else begin
            failCount++;
            $error("CHECK FAILED extend: expected %h actual %h", expExt, extImm);
        end

    branchFlag: assert property (@(negedge clk) disable iff (rst) isBranch == isXfer)
        else begin
            failCount++;
            $error("CHECK FAILED branchFlag: expected %b actual %b", isXfer, isBranch);
        end

endmodule

bind idStage idStage_checker chk (.*);

//--- sim/idStage_tb.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module idStage_tb;
    import mips_pkg::*;

    localparam int clkPeriod   = 4;
    localparam int dirCount    = 23;  // directed instruction kinds
    localparam int dirRounds   = 8;
    localparam int mixCycles   = 300;
    localparam int totalCycles = 2 + `MIPS_REG_COUNT + dirCount * dirRounds + mixCycles;
    localparam logic [31:0] lfsrTaps = 32'h80200003;

    logic                            clk;
    logic                            rst;
    instrUnion                       inst;
    logic [`MIPS_DATA_WIDTH-1:0]     pc;
    logic                            wbWriteEnable;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] wbWriteAddr;
    logic [`MIPS_DATA_WIDTH-1:0]     wbWriteData;
    logic [`MIPS_DATA_WIDTH-1:0]     rsValue;
    logic [`MIPS_DATA_WIDTH-1:0]     rtValue;
    logic [`MIPS_DATA_WIDTH-1:0]     extImm;
    logic [`MIPS_DATA_WIDTH-1:0]     idData;
    logic [`MIPS_DATA_WIDTH-1:0]     branchTarget;
    logic                            branchTaken;
    logic                            isBranch;
    logic [31:0]                     lfsr;
    int                              cycles = 0;

    idStage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = galoisStep(lfsr);
        end
    endtask

    task automatic buildInst(input int k, output logic [31:0] w);
        logic [31:0] f;
        takeBits(26, f);
        case (k)
            // f[15] makes rt a copy of rs so the equal case comes up often
            0:  w = {opBeq, f[25:21], (f[15] ? f[25:21] : f[20:16]), f[15:0]};
            1:  w = {opBne, f[25:21], (f[15] ? f[25:21] : f[20:16]), f[15:0]};
            2:  w = {opBlez, f[25:0]};
            3:  w = {opBgtz, f[25:0]};
            4:  w = {opRegimm, f[25:21], rtBltz, f[15:0]};
            5:  w = {opRegimm, f[25:21], rtBgez, f[15:0]};
            6:  w = {opRegimm, f[25:21], rtBltzal, f[15:0]};
            7:  w = {opRegimm, f[25:21], rtBgezal, f[15:0]};
            8:  w = {opJ, f[25:0]};
            9:  w = {opJal, f[25:0]};
            10: w = {opSpecial, f[25:6], fnJr};
            11: w = {opSpecial, f[25:6], fnJalr};
            12: w = {opSpecial, f[25:6], fnSlt};
            13: w = {opSpecial, f[25:6], fnSltu};
            14: w = {opSlti, f[25:0]};
            15: w = {opSltiu, f[25:0]};
            16: w = {opLui, f[25:0]};
            17: w = {opAddi, f[25:0]};
            18: w = {opAddiu, f[25:0]};
            19: w = {opOri, f[25:0]};
            20: w = {opLw, f[25:0]};
            21: w = {opSw, f[25:0]};
            default: w = {opSpecial, f[25:6], fnAddu};
        endcase
    endtask

    task automatic applyCycle(input logic [31:0] w, input logic we,
                              input logic [4:0] wa, input logic [31:0] wd);
        logic [31:0] p;
        takeBits(30, p);
        @(posedge clk);
        inst          <= w;
        pc            <= {p[29:0], 2'b00};  // word aligned
        wbWriteEnable <= we;
        wbWriteAddr   <= wa;
        wbWriteData   <= wd;
        cycles++;
    endtask

    initial begin
        #((totalCycles + 20) * clkPeriod);
        $display("timeout: stimulus did not finish within %0d cycles", totalCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [31:0] d;
        logic [31:0] f;
        lfsr          = 32'd8;
        rst           = 1'b1;
        inst          = '0;
        pc            = '0;
        wbWriteEnable = 1'b0;
        wbWriteAddr   = '0;
        wbWriteData   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // fill phase reads the written reg through the bypass and the next one at reset
        for (int r = 0; r < `MIPS_REG_COUNT; r++) begin
            takeBits(32, d);
            applyCycle({opSpecial, 5'(r), 5'(r + 1), 10'd0, fnAddu}, 1'b1, 5'(r), d);
        end

        for (int n = 0; n < dirRounds * dirCount; n++) begin
            buildInst(n % dirCount, w);
            applyCycle(w, 1'b0, '0, '0);
        end

        for (int n = 0; n < mixCycles; n++) begin
            takeBits(5, f);
            buildInst(int'(f[4:0]) % dirCount, w);
            takeBits(32, d);
            takeBits(7, f);
            applyCycle(w, f[0], f[1] ? w[25:21] : f[6:2], d);  // f[1] aims the write at rs
        end
        @(posedge clk);

        $display("done: %0d cycles, %0d failed checks", cycles, DUT.chk.failCount);
        if (DUT.chk.failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/mips_pkg.sv
id/idController.sv
id/idComparer.sv
id/idOperand.sv
id/idNextPc.sv
rtl/regFile.sv
id/idStage.sv
sim/idStage_checker.sv
sim/idStage_tb.sv
